//--- lane_params.svh
`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

// Port counts of one lane
`define LANE_R_PORTS    4
`define LANE_W_PORTS    2

// Storage sizes
`define LANE_VRF_DEPTH  64
`define LANE_VMRF_DEPTH 32
`define LANE_WORD_W     32

// Read request to extracted element, in cycles
`define LANE_READ_LAT   2

// Write command to VRF/VMRF commit, in cycles
`define LANE_WB_LAT     2

`endif

//--- lane_pkg.sv
`include "lane_params.svh"

package lane_pkg;

   // Data and address widths
   typedef logic [`LANE_WORD_W-1:0]               elem_t;
   typedef logic [$clog2(`LANE_VRF_DEPTH)-1:0]    vrf_addr_t;
   typedef logic [$clog2(`LANE_VMRF_DEPTH)-1:0]   vmrf_addr_t;
   typedef logic [`LANE_WORD_W/8-1:0]             byte_en_t;

   // Byte position inside a word
   typedef logic [$clog2(`LANE_WORD_W/8)-1:0]     el_idx_t;
   typedef logic [$clog2(`LANE_R_PORTS)-1:0]      rport_sel_t;

   // Element width, code 3 extracts zero
   typedef enum logic [1:0] {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2
   } sew_e;

   // Write-back source, code 3 writes zero
   typedef enum logic [1:0] {
      WB_ALU   = 2'd0,
      WB_LOAD  = 2'd1,
      WB_SLIDE = 2'd2
   } wb_src_e;

endpackage

//--- lane_regfile.sv
`include "lane_params.svh"

module lane_regfile #(
   parameter int WIDTH = `LANE_WORD_W,
   parameter int DEPTH = `LANE_VRF_DEPTH,
   parameter int N_RD  = `LANE_R_PORTS,
   parameter int N_WR  = `LANE_W_PORTS,
   localparam int AW   = $clog2(DEPTH),
   localparam int BE_W = (WIDTH + 7) / 8
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic [N_RD-1:0]              ren_i,
   input  logic [N_RD-1:0][AW-1:0]      raddr_i,
   output logic [N_RD-1:0][WIDTH-1:0]   rdata_o,
   input  logic [N_WR-1:0][AW-1:0]      waddr_i,
   input  logic [N_WR-1:0][BE_W-1:0]    wbe_i,
   input  logic [N_WR-1:0][WIDTH-1:0]   wdata_i
);

   logic [WIDTH-1:0] mem [DEPTH];

   ////////////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////////////

   // Highest port first, so a lower port lands last on a clash
   always_ff @(posedge clk_i) begin
      for (int w = N_WR - 1; w >= 0; w--) begin
         for (int b = 0; b < WIDTH; b++) begin
            if (wbe_i[w][b / 8]) begin
               mem[waddr_i[w]][b] <= wdata_i[w][b];
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////////////////////

   // One-cycle read, holds its word while the port is idle.
   // Same-cycle write to the read address returns the old word.
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rdata_o <= '0;
      end else begin
         for (int r = 0; r < N_RD; r++) begin
            if (ren_i[r]) begin
               rdata_o[r] <= mem[raddr_i[r]];
            end
         end
      end
   end

   // Write ports must target distinct words
   generate
      for (genvar p = 0; p < N_WR; p++) begin : g_clash_p
         for (genvar q = p + 1; q < N_WR; q++) begin : g_clash_q
            a_no_write_clash: assert property (
               @(posedge clk_i) disable iff (!rst_i)
               (|wbe_i[p] && |wbe_i[q]) |-> (waddr_i[p] != waddr_i[q])
            ) else $error("write ports %0d and %0d hit address %0d", p, q, waddr_i[p]);
         end
      end
   endgenerate

endmodule

//--- lane_elem_extract.sv
`include "lane_params.svh"

module lane_elem_extract import lane_pkg::*; (
   input  logic                              clk_i,
   input  logic                              rst_i,
   input  elem_t   [`LANE_R_PORTS-1:0]       raw_i,
   input  el_idx_t [`LANE_R_PORTS-1:0]       el_idx_i,
   input  sew_e                              sew_i,
   output elem_t   [`LANE_R_PORTS-1:0]       elem_o,
   output sew_e                              sew_d_o
);

   localparam int R = `LANE_R_PORTS;

   el_idx_t [R-1:0] idx_d;
   sew_e            sew_d;

   // Index and SEW follow the request into the raw-word cycle
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         idx_d <= '0;
         sew_d <= SEW_8;
      end else begin
         idx_d <= el_idx_i;
         sew_d <= sew_i;
      end
   end

   assign sew_d_o = sew_d;

   ////////////////////////////////////////////////////////////////////////////
   // Per-port element select
   ////////////////////////////////////////////////////////////////////////////

   generate
      for (genvar p = 0; p < R; p++) begin : g_port
         logic [7:0]  sel_byte;
         logic [15:0] sel_half;
         elem_t       elem_next;

         assign sel_byte = raw_i[p][{idx_d[p], 3'b000} +: 8];
         // Halfword picked by the low index bit only
         assign sel_half = raw_i[p][{idx_d[p][0], 4'b0000} +: 16];

         always_comb begin
            case (sew_d)
               SEW_8:   elem_next = elem_t'(sel_byte);
               SEW_16:  elem_next = elem_t'(sel_half);
               SEW_32:  elem_next = raw_i[p];
               default: elem_next = '0;
            endcase
         end

         // Output stage, second cycle of the read latency
         always_ff @(posedge clk_i) begin
            if (!rst_i) begin
               elem_o[p] <= '0;
            end else begin
               elem_o[p] <= elem_next;
            end
         end
      end
   endgenerate

endmodule

//--- lane_operand_route.sv
`include "lane_params.svh"

module lane_operand_route import lane_pkg::*; (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  elem_t      [`LANE_R_PORTS-1:0]      elem_i,
   input  logic       [`LANE_R_PORTS-1:0]      ren_i,
   input  logic       [`LANE_W_PORTS-1:0]      read_valid_i,
   input  logic       [`LANE_W_PORTS-1:0]      store_valid_i,
   input  rport_sel_t [`LANE_W_PORTS-1:0]      store_sel_i,
   output elem_t      [`LANE_W_PORTS-1:0]      vs1_o,
   output elem_t      [`LANE_W_PORTS-1:0]      vs2_o,
   output logic       [`LANE_W_PORTS-1:0]      alu_vld_o,
   output elem_t      [`LANE_W_PORTS-1:0]      store_data_o,
   output logic       [`LANE_W_PORTS-1:0]      store_valid_o
);

   localparam int R = `LANE_R_PORTS;
   localparam int W = `LANE_W_PORTS;
   localparam int D = `LANE_READ_LAT;

   // Control delay line, last stage matches elem_i
   logic       [D-1:0][W-1:0] rvld_q;
   logic       [D-1:0][W-1:0] svld_q;
   rport_sel_t [D-1:0][W-1:0] ssel_q;
   logic       [D-1:0][R-1:0] ren_q;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rvld_q <= '0;
         svld_q <= '0;
         ssel_q <= '0;
         ren_q  <= '0;
      end else begin
         rvld_q <= {rvld_q[D-2:0], read_valid_i};
         svld_q <= {svld_q[D-2:0], store_valid_i};
         ssel_q <= {ssel_q[D-2:0], store_sel_i};
         ren_q  <= {ren_q[D-2:0], ren_i};
      end
   end

   assign alu_vld_o     = rvld_q[D-1];
   assign store_valid_o = svld_q[D-1];

   generate
      for (genvar j = 0; j < W; j++) begin : g_wport
         // Even port feeds vs1, odd port feeds vs2
         assign vs1_o[j]        = elem_i[2 * j];
         assign vs2_o[j]        = elem_i[2 * j + 1];
         assign store_data_o[j] = elem_i[ssel_q[D-1][j]];

         a_store_port_read: assert property (
            @(posedge clk_i) disable iff (!rst_i)
            store_valid_o[j] |-> ren_q[D-1][ssel_q[D-1][j]]
         ) else $error("store %0d selects port %0d that was not read", j, ssel_q[D-1][j]);
      end
   endgenerate

endmodule

//--- lane_writeback.sv
`include "lane_params.svh"

module lane_writeback import lane_pkg::*; (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic       [`LANE_W_PORTS-1:0]      alu_vld_i,
   input  elem_t      [`LANE_W_PORTS-1:0]      alu_res_i,
   input  logic       [`LANE_W_PORTS-1:0]      alu_mask_i,
   input  elem_t                               load_data_i,
   input  elem_t                               slide_data_i,
   input  wb_src_e    [`LANE_W_PORTS-1:0]      wb_sel_i,
   input  vrf_addr_t  [`LANE_W_PORTS-1:0]      waddr_i,
   input  byte_en_t   [`LANE_W_PORTS-1:0]      bwen_i,
   input  logic       [`LANE_W_PORTS-1:0]      vector_mask_i,
   input  vmrf_addr_t [`LANE_W_PORTS-1:0]      vmrf_addr_i,
   input  logic       [`LANE_W_PORTS-1:0]      vmrf_wen_i,
   input  logic       [`LANE_W_PORTS-1:0]      request_i,
   input  logic       [`LANE_W_PORTS-1:0]      vmrf_bit_i,
   output vrf_addr_t  [`LANE_W_PORTS-1:0]      vrf_waddr_o,
   output byte_en_t   [`LANE_W_PORTS-1:0]      vrf_wbe_o,
   output elem_t      [`LANE_W_PORTS-1:0]      vrf_wdata_o,
   output vmrf_addr_t [`LANE_W_PORTS-1:0]      vmrf_raddr_o,
   output vmrf_addr_t [`LANE_W_PORTS-1:0]      vmrf_waddr_o,
   output logic       [`LANE_W_PORTS-1:0]      vmrf_wbe_o,
   output logic       [`LANE_W_PORTS-1:0]      vmrf_wdata_o
);

   localparam int W = `LANE_W_PORTS;
   localparam int D = `LANE_WB_LAT;

   elem_t [D-1:0] slide_q;
   elem_t [W-1:0] src_word;

   // Command pipeline, stage D-1 is the commit stage
   logic       [D-1:0][W-1:0] en_q;
   vrf_addr_t  [D-1:0][W-1:0] waddr_q;
   byte_en_t   [D-1:0][W-1:0] bwen_q;
   elem_t      [D-1:0][W-1:0] wdata_q;
   logic       [D-1:0][W-1:0] vm_q;
   vmrf_addr_t [D-1:0][W-1:0] vmaddr_q;
   logic       [D-1:0][W-1:0] vmwen_q;
   logic       [D-1:0][W-1:0] vmbit_q;

   ////////////////////////////////////////////////////////////////////////////
   // Source select
   ////////////////////////////////////////////////////////////////////////////

   // Slide data from two cycles before the command
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         slide_q <= '0;
      end else begin
         slide_q <= {slide_q[D-2:0], slide_data_i};
      end
   end

   generate
      for (genvar j = 0; j < W; j++) begin : g_src
         always_comb begin
            case (wb_sel_i[j])
               WB_ALU:   src_word[j] = alu_res_i[j];
               WB_LOAD:  src_word[j] = load_data_i;
               WB_SLIDE: src_word[j] = slide_q[D-1];
               default:  src_word[j] = '0;
            endcase
         end

         a_wb_sel_legal: assert property (
            @(posedge clk_i) disable iff (!rst_i)
            (alu_vld_i[j] || request_i[j]) |-> (wb_sel_i[j] inside {WB_ALU, WB_LOAD, WB_SLIDE})
         ) else $error("write port %0d has an undefined source code", j);
      end
   endgenerate

   ////////////////////////////////////////////////////////////////////////////
   // Command pipeline
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         en_q     <= '0;
         waddr_q  <= '0;
         bwen_q   <= '0;
         wdata_q  <= '0;
         vm_q     <= '0;
         vmaddr_q <= '0;
         vmwen_q  <= '0;
         vmbit_q  <= '0;
      end else begin
         en_q[0]     <= alu_vld_i | request_i;
         waddr_q[0]  <= waddr_i;
         bwen_q[0]   <= bwen_i;
         wdata_q[0]  <= src_word;
         vm_q[0]     <= vector_mask_i;
         vmaddr_q[0] <= vmrf_addr_i;
         vmwen_q[0]  <= vmrf_wen_i;
         vmbit_q[0]  <= alu_mask_i;
         for (int k = 1; k < D; k++) begin
            en_q[k]     <= en_q[k-1];
            waddr_q[k]  <= waddr_q[k-1];
            bwen_q[k]   <= bwen_q[k-1];
            wdata_q[k]  <= wdata_q[k-1];
            vm_q[k]     <= vm_q[k-1];
            vmaddr_q[k] <= vmaddr_q[k-1];
            vmwen_q[k]  <= vmwen_q[k-1];
            vmbit_q[k]  <= vmbit_q[k-1];
         end
      end
   end

   // VMRF read one stage early so the bit arrives at commit
   assign vmrf_raddr_o = vmaddr_q[D-2];

   assign vrf_waddr_o  = waddr_q[D-1];
   assign vrf_wdata_o  = wdata_q[D-1];
   assign vmrf_waddr_o = vmaddr_q[D-1];
   assign vmrf_wdata_o = vmbit_q[D-1];
   assign vmrf_wbe_o   = en_q[D-1] & vmwen_q[D-1];

   generate
      for (genvar j = 0; j < W; j++) begin : g_commit
         // Masked write keeps bytes only where the mask bit is set
         assign vrf_wbe_o[j] = !en_q[D-1][j] ? '0 :
                               vm_q[D-1][j] ? (bwen_q[D-1][j] & {$bits(byte_en_t){vmrf_bit_i[j]}}) :
                                              bwen_q[D-1][j];
      end
   endgenerate

endmodule

//--- vector_lane.sv
`include "lane_params.svh"

module vector_lane import lane_pkg::*; (
   input  logic                                clk_i,
   input  logic                                rst_i,
   // Read requests
   input  logic       [`LANE_R_PORTS-1:0]      vrf_ren_i,
   input  vrf_addr_t  [`LANE_R_PORTS-1:0]      vrf_raddr_i,
   input  el_idx_t    [`LANE_R_PORTS-1:0]      el_idx_i,
   input  sew_e                                sew_i,
   input  logic       [`LANE_W_PORTS-1:0]      read_valid_i,
   input  logic       [`LANE_W_PORTS-1:0]      store_valid_i,
   input  rport_sel_t [`LANE_W_PORTS-1:0]      store_sel_i,
   // ALU return and write commands
   input  logic       [`LANE_W_PORTS-1:0]      alu_vld_i,
   input  elem_t      [`LANE_W_PORTS-1:0]      alu_res_i,
   input  logic       [`LANE_W_PORTS-1:0]      alu_mask_i,
   input  elem_t                               load_data_i,
   input  elem_t                               slide_data_i,
   input  wb_src_e    [`LANE_W_PORTS-1:0]      wb_sel_i,
   input  vrf_addr_t  [`LANE_W_PORTS-1:0]      waddr_i,
   input  byte_en_t   [`LANE_W_PORTS-1:0]      bwen_i,
   input  logic       [`LANE_W_PORTS-1:0]      vector_mask_i,
   input  vmrf_addr_t [`LANE_W_PORTS-1:0]      vmrf_addr_i,
   input  logic       [`LANE_W_PORTS-1:0]      vmrf_wen_i,
   input  logic       [`LANE_W_PORTS-1:0]      request_i,
   // ALU operands, store and slide data
   output elem_t      [`LANE_W_PORTS-1:0]      vs1_o,
   output elem_t      [`LANE_W_PORTS-1:0]      vs2_o,
   output logic       [`LANE_W_PORTS-1:0]      alu_vld_o,
   output elem_t      [`LANE_W_PORTS-1:0]      store_data_o,
   output logic       [`LANE_W_PORTS-1:0]      store_valid_o,
   output elem_t                               slide_data_o
);

   localparam int R = `LANE_R_PORTS;
   localparam int W = `LANE_W_PORTS;

   elem_t      [R-1:0] vrf_rdata;
   elem_t      [R-1:0] elem;
   vrf_addr_t  [W-1:0] vrf_waddr;
   byte_en_t   [W-1:0] vrf_wbe;
   elem_t      [W-1:0] vrf_wdata;
   vmrf_addr_t [W-1:0] vmrf_raddr;
   vmrf_addr_t [W-1:0] vmrf_waddr;
   logic       [W-1:0] vmrf_wbe;
   logic       [W-1:0] vmrf_wdata;
   logic       [W-1:0] vmrf_rdata;

   // Raw port 1 word is the slide source
   assign slide_data_o = vrf_rdata[1];

   ////////////////////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////////////////////

   lane_regfile #(
      .WIDTH (`LANE_WORD_W),
      .DEPTH (`LANE_VRF_DEPTH),
      .N_RD  (R),
      .N_WR  (W)
   ) vrf_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .ren_i   (vrf_ren_i),
      .raddr_i (vrf_raddr_i),
      .rdata_o (vrf_rdata),
      .waddr_i (vrf_waddr),
      .wbe_i   (vrf_wbe),
      .wdata_i (vrf_wdata)
   );

   // One mask bit per element, read every cycle
   lane_regfile #(
      .WIDTH (1),
      .DEPTH (`LANE_VMRF_DEPTH),
      .N_RD  (W),
      .N_WR  (W)
   ) vmrf_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .ren_i   ('1),
      .raddr_i (vmrf_raddr),
      .rdata_o (vmrf_rdata),
      .waddr_i (vmrf_waddr),
      .wbe_i   (vmrf_wbe),
      .wdata_i (vmrf_wdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Read path and write-back
   ////////////////////////////////////////////////////////////////////////////

   lane_elem_extract extract_inst (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .raw_i    (vrf_rdata),
      .el_idx_i (el_idx_i),
      .sew_i    (sew_i),
      .elem_o   (elem),
      // Delayed SEW tap for an ALU that needs it
      .sew_d_o  ()
   );

   lane_operand_route route_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .elem_i        (elem),
      .ren_i         (vrf_ren_i),
      .read_valid_i  (read_valid_i),
      .store_valid_i (store_valid_i),
      .store_sel_i   (store_sel_i),
      .vs1_o         (vs1_o),
      .vs2_o         (vs2_o),
      .alu_vld_o     (alu_vld_o),
      .store_data_o  (store_data_o),
      .store_valid_o (store_valid_o)
   );

   lane_writeback wb_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .alu_vld_i     (alu_vld_i),
      .alu_res_i     (alu_res_i),
      .alu_mask_i    (alu_mask_i),
      .load_data_i   (load_data_i),
      .slide_data_i  (slide_data_i),
      .wb_sel_i      (wb_sel_i),
      .waddr_i       (waddr_i),
      .bwen_i        (bwen_i),
      .vector_mask_i (vector_mask_i),
      .vmrf_addr_i   (vmrf_addr_i),
      .vmrf_wen_i    (vmrf_wen_i),
      .request_i     (request_i),
      .vmrf_bit_i    (vmrf_rdata),
      .vrf_waddr_o   (vrf_waddr),
      .vrf_wbe_o     (vrf_wbe),
      .vrf_wdata_o   (vrf_wdata),
      .vmrf_raddr_o  (vmrf_raddr),
      .vmrf_waddr_o  (vmrf_waddr),
      .vmrf_wbe_o    (vmrf_wbe),
      .vmrf_wdata_o  (vmrf_wdata)
   );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD       = 8,
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // Active-low reset, released on a rising edge
   initial begin
      rst_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b1;
   end

endmodule

//--- tb_vector_lane.sv
`include "lane_params.svh"

module tb_vector_lane
   import lane_pkg::*;
();

   localparam int W                = `LANE_W_PORTS;
   localparam int R                = `LANE_R_PORTS;
   localparam int LAT              = `LANE_READ_LAT;
   localparam int CLK_PERIOD       = 8;
   localparam int RESET_CYCLES     = 10;
   localparam int CYCLES_PER_ENTRY = 10;
   localparam int SETTLE_CYCLES    = 3;
   localparam int unsigned RNG_SEED = 32'hb783_18f6;

   typedef enum logic [1:0] {K_LOAD, K_READ, K_ALU, K_SLIDE} kind_e;

   // Read source, write target and mask control of one table row
   typedef struct packed {
      kind_e      kind;
      logic       port;
      vrf_addr_t  addr;
      vrf_addr_t  dst;
      el_idx_t    idx;
      rport_sel_t sel;
      sew_e       sew;
      byte_en_t   be;
      logic       vm;
      vmrf_addr_t vmaddr;
      logic       vmwen;
      elem_t      data;
   } entry_t;

   logic                clk;
   logic                rst;
   logic       [R-1:0]  vrf_ren;
   vrf_addr_t  [R-1:0]  vrf_raddr;
   el_idx_t    [R-1:0]  el_idx;
   sew_e                sew;
   logic       [W-1:0]  read_valid;
   logic       [W-1:0]  store_valid;
   rport_sel_t [W-1:0]  store_sel;
   logic       [W-1:0]  alu_vld_in;
   elem_t      [W-1:0]  alu_res;
   logic       [W-1:0]  alu_mask;
   elem_t               load_data;
   elem_t               slide_data_in;
   wb_src_e    [W-1:0]  wb_sel;
   vrf_addr_t  [W-1:0]  waddr;
   byte_en_t   [W-1:0]  bwen;
   logic       [W-1:0]  vector_mask;
   vmrf_addr_t [W-1:0]  vmrf_addr;
   logic       [W-1:0]  vmrf_wen;
   logic       [W-1:0]  request;
   elem_t      [W-1:0]  vs1;
   elem_t      [W-1:0]  vs2;
   logic       [W-1:0]  alu_vld;
   elem_t      [W-1:0]  store_data;
   logic       [W-1:0]  store_valid_out;
   elem_t               slide_data;

   entry_t      tbl [$];
   elem_t       ref_vrf [`LANE_VRF_DEPTH];
   logic        ref_vmrf [`LANE_VMRF_DEPTH];
   int          n_checks;
   int          n_errors;
   logic        table_ready;

   tb_clock_gen #(
      .PERIOD       (CLK_PERIOD),
      .RESET_CYCLES (RESET_CYCLES)
   ) clock_inst (
      .clk_o (clk),
      .rst_o (rst)
   );

   vector_lane UUT (
      .clk_i         (clk),
      .rst_i         (rst),
      .vrf_ren_i     (vrf_ren),
      .vrf_raddr_i   (vrf_raddr),
      .el_idx_i      (el_idx),
      .sew_i         (sew),
      .read_valid_i  (read_valid),
      .store_valid_i (store_valid),
      .store_sel_i   (store_sel),
      .alu_vld_i     (alu_vld_in),
      .alu_res_i     (alu_res),
      .alu_mask_i    (alu_mask),
      .load_data_i   (load_data),
      .slide_data_i  (slide_data_in),
      .wb_sel_i      (wb_sel),
      .waddr_i       (waddr),
      .bwen_i        (bwen),
      .vector_mask_i (vector_mask),
      .vmrf_addr_i   (vmrf_addr),
      .vmrf_wen_i    (vmrf_wen),
      .request_i     (request),
      .vs1_o         (vs1),
      .vs2_o         (vs2),
      .alu_vld_o     (alu_vld),
      .store_data_o  (store_data),
      .store_valid_o (store_valid_out),
      .slide_data_o  (slide_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks and reference model
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_elem(input elem_t got, input elem_t exp, input string msg);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at time %0t: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string msg);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at time %0t: %s, got %b, expected %b", $time, msg, got, exp);
      end
   endtask

   // Zero-extended element of a stored word
   function automatic elem_t extract_ref(input elem_t word, input sew_e s, input el_idx_t idx);
      case (s)
         SEW_8:   return elem_t'(word[idx * 8 +: 8]);
         SEW_16:  return elem_t'(word[idx[0] * 16 +: 16]);
         SEW_32:  return word;
         default: return '0;
      endcase
   endfunction

   // Byte-enabled VRF update gated by the old mask bit
   task automatic ref_commit(input entry_t e, input elem_t word, input logic mbit);
      byte_en_t eff;
      eff = e.vm ? (e.be & {$bits(byte_en_t){ref_vmrf[e.vmaddr]}}) : e.be;
      for (int b = 0; b < $bits(byte_en_t); b++) begin
         if (eff[b]) begin
            ref_vrf[e.dst][8 * b +: 8] = word[8 * b +: 8];
         end
      end
      if (e.vmwen) begin
         ref_vmrf[e.vmaddr] = mbit;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Drivers
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive_idle();
      vrf_ren       <= '0;
      vrf_raddr     <= '0;
      el_idx        <= '0;
      sew           <= SEW_32;
      read_valid    <= '0;
      store_valid   <= '0;
      store_sel     <= '0;
      alu_vld_in    <= '0;
      alu_res       <= '0;
      alu_mask      <= '0;
      load_data     <= '0;
      slide_data_in <= '0;
      waddr         <= '0;
      bwen          <= '0;
      vector_mask   <= '0;
      vmrf_addr     <= '0;
      vmrf_wen      <= '0;
      request       <= '0;
      for (int j = 0; j < W; j++) begin
         wb_sel[j] <= WB_ALU;
      end
   endtask

   task automatic drive_write(input int j, input wb_src_e src, input elem_t word, input entry_t e);
      wb_sel[j]      <= src;
      waddr[j]       <= e.dst;
      bwen[j]        <= e.be;
      vector_mask[j] <= e.vm;
      vmrf_addr[j]   <= e.vmaddr;
      vmrf_wen[j]    <= e.vmwen;
      if (src == WB_ALU) begin
         alu_vld_in[j] <= 1'b1;
         alu_res[j]    <= word;
         alu_mask[j]   <= word[0];
      end else begin
         request[j] <= 1'b1;
         load_data  <= word;
      end
   endtask

   // Valid flags stay low until the fixed read latency is reached
   task automatic await_read(input logic [W-1:0] rv, input logic [W-1:0] sv, input int n);
      for (int k = 1; k <= LAT; k++) begin
         @(negedge clk);
         for (int j = 0; j < W; j++) begin
            check_valid(alu_vld[j], rv[j] && (k == LAT),
                        $sformatf("entry %0d alu_vld_o[%0d] cycle %0d", n, j, k));
            check_valid(store_valid_out[j], sv[j] && (k == LAT),
                        $sformatf("entry %0d store_valid_o[%0d] cycle %0d", n, j, k));
         end
         if (k < LAT) begin
            @(posedge clk);
         end
      end
   endtask

   task automatic run_load(input entry_t e);
      elem_t word;
      word = (e.data != '0) ? e.data : elem_t'($urandom());
      @(posedge clk);
      drive_write(e.port, WB_LOAD, word, e);
      @(posedge clk);
      drive_idle();
      ref_commit(e, word, 1'b0);
   endtask

   // All four ports read one word at their own indexes
   task automatic run_read(input entry_t e, input int n);
      elem_t      exp_el [R];
      rport_sel_t ssel [W];
      for (int p = 0; p < R; p++) begin
         exp_el[p] = extract_ref(ref_vrf[e.addr], e.sew, el_idx_t'(e.idx + p));
      end
      for (int j = 0; j < W; j++) begin
         ssel[j] = rport_sel_t'(e.sel + 2 * j);
      end
      @(posedge clk);
      for (int p = 0; p < R; p++) begin
         vrf_ren[p]   <= 1'b1;
         vrf_raddr[p] <= e.addr;
         el_idx[p]    <= el_idx_t'(e.idx + p);
      end
      for (int j = 0; j < W; j++) begin
         store_sel[j] <= ssel[j];
      end
      sew         <= e.sew;
      read_valid  <= '1;
      store_valid <= '1;
      @(posedge clk);
      drive_idle();
      await_read('1, '1, n);
      for (int j = 0; j < W; j++) begin
         check_elem(vs1[j], exp_el[2 * j], $sformatf("entry %0d vs1_o[%0d]", n, j));
         check_elem(vs2[j], exp_el[2 * j + 1], $sformatf("entry %0d vs2_o[%0d]", n, j));
         check_elem(store_data[j], exp_el[ssel[j]],
                    $sformatf("entry %0d store_data_o[%0d]", n, j));
      end
   endtask

   // ALU model adds the operands of ports 2j and 2j+1
   task automatic run_alu(input entry_t e, input int n);
      int             j;
      elem_t          exp_a;
      elem_t          exp_b;
      elem_t          sum;
      logic [W-1:0]   rv;
      j = e.port;
      rv = '0;
      rv[j] = 1'b1;
      exp_a = ref_vrf[e.addr];
      exp_b = ref_vrf[vrf_addr_t'(e.addr + 1)];
      @(posedge clk);
      vrf_ren[2 * j]       <= 1'b1;
      vrf_ren[2 * j + 1]   <= 1'b1;
      vrf_raddr[2 * j]     <= e.addr;
      vrf_raddr[2 * j + 1] <= vrf_addr_t'(e.addr + 1);
      read_valid[j]        <= 1'b1;
      @(posedge clk);
      drive_idle();
      await_read(rv, '0, n);
      check_elem(vs1[j], exp_a, $sformatf("entry %0d vs1_o[%0d]", n, j));
      check_elem(vs2[j], exp_b, $sformatf("entry %0d vs2_o[%0d]", n, j));
      sum = vs1[j] + vs2[j];
      @(posedge clk);
      drive_write(j, WB_ALU, sum, e);
      @(posedge clk);
      drive_idle();
      ref_commit(e, exp_a + exp_b, exp_a[0] ^ exp_b[0]);
   endtask

   // Slide word is sent two cycles ahead of its write command
   task automatic run_slide(input entry_t e, input int n);
      elem_t sval;
      elem_t exp_raw;
      sval = (e.data != '0) ? e.data : elem_t'($urandom());
      exp_raw = ref_vrf[e.addr];
      @(posedge clk);
      vrf_ren[1]    <= 1'b1;
      vrf_raddr[1]  <= e.addr;
      slide_data_in <= sval;
      @(posedge clk);
      drive_idle();
      slide_data_in <= elem_t'($urandom());
      @(negedge clk);
      check_elem(slide_data, exp_raw, $sformatf("entry %0d slide_data_o", n));
      @(posedge clk);
      drive_write(e.port, WB_SLIDE, '0, e);
      slide_data_in <= elem_t'($urandom());
      @(posedge clk);
      drive_idle();
      ref_commit(e, sval, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////////////////////

   function automatic void add_entry(input kind_e kind, input logic port, input vrf_addr_t addr,
                                     input vrf_addr_t dst, input el_idx_t idx,
                                     input rport_sel_t sel, input sew_e s, input byte_en_t be,
                                     input logic vm, input vmrf_addr_t vmaddr,
                                     input logic vmwen, input elem_t data);
      tbl.push_back('{kind, port, addr, dst, idx, sel, s, be, vm, vmaddr, vmwen, data});
   endfunction

   // Data 0 on a write row means a random word
   function automatic void build_table();
      //        kind     prt src dst idx sel sew     be    vm vma vmw data
      add_entry(K_LOAD,  0,  0,  4,  0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h0);
      add_entry(K_LOAD,  1,  0,  5,  0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'ha1b2_c3d4);
      add_entry(K_LOAD,  0,  0,  8,  0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h0000_1003);
      add_entry(K_LOAD,  1,  0,  9,  0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h2000_0100);
      add_entry(K_LOAD,  0,  0,  10, 0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h0000_0022);
      add_entry(K_LOAD,  1,  0,  11, 0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h0044_0000);
      add_entry(K_LOAD,  0,  0,  20, 0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h0);
      add_entry(K_LOAD,  1,  0,  21, 0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  4,  0,  0,  1,  SEW_32, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_LOAD,  1,  0,  4,  0,  0,  SEW_32, 4'h5, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  4,  0,  0,  2,  SEW_32, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  5,  0,  0,  3,  SEW_8,  4'h0, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  5,  0,  0,  0,  SEW_16, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  4,  0,  1,  1,  SEW_8,  4'h0, 0, 0,  0,  32'h0);
      add_entry(K_ALU,   0,  8,  12, 0,  0,  SEW_32, 4'hf, 0, 3,  1,  32'h0);
      add_entry(K_ALU,   1,  10, 13, 0,  0,  SEW_32, 4'hf, 0, 7,  1,  32'h0);
      add_entry(K_READ,  0,  12, 0,  0,  0,  SEW_32, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  13, 0,  2,  1,  SEW_16, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_LOAD,  0,  0,  20, 0,  0,  SEW_32, 4'hf, 1, 3,  0,  32'h0);
      add_entry(K_LOAD,  1,  0,  21, 0,  0,  SEW_32, 4'hf, 1, 7,  0,  32'h0);
      add_entry(K_READ,  0,  20, 0,  0,  0,  SEW_32, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  21, 0,  0,  3,  SEW_32, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_ALU,   1,  10, 20, 0,  0,  SEW_32, 4'h3, 1, 3,  0,  32'h0);
      add_entry(K_READ,  0,  20, 0,  0,  2,  SEW_8,  4'h0, 0, 0,  0,  32'h0);
      add_entry(K_SLIDE, 0,  5,  24, 0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'hcafe_0001);
      add_entry(K_SLIDE, 1,  12, 25, 0,  0,  SEW_32, 4'hf, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  24, 0,  0,  0,  SEW_32, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  25, 0,  0,  1,  SEW_32, 4'h0, 0, 0,  0,  32'h0);
      add_entry(K_READ,  0,  24, 0,  1,  3,  SEW_16, 4'h0, 0, 0,  0,  32'h0);
   endfunction

   initial begin
      n_checks = 0;
      n_errors = 0;
      table_ready = 1'b0;
      void'($urandom(RNG_SEED));
      drive_idle();
      build_table();
      table_ready = 1'b1;
      wait (rst === 1'b1);
      for (int n = 0; n < tbl.size(); n++) begin
         case (tbl[n].kind)
            K_LOAD:  run_load(tbl[n]);
            K_READ:  run_read(tbl[n], n);
            K_ALU:   run_alu(tbl[n], n);
            default: run_slide(tbl[n], n);
         endcase
         repeat (SETTLE_CYCLES) @(posedge clk);
      end
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      wait (table_ready === 1'b1);
      #((tbl.size() * CYCLES_PER_ENTRY + RESET_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before the stimulus table was finished");
      $display("Test failed");
      $finish;
   end

endmodule

//--- all.f
+incdir+.
lane_pkg.sv
lane_regfile.sv
lane_elem_extract.sv
lane_operand_route.sv
lane_writeback.sv
vector_lane.sv
tb_clock_gen.sv
tb_vector_lane.sv
